/* logic/packet_pkg.sv */
package packet_pkg;

    // ====================
    // Beat geometry
    // ====================
    localparam int NARROW_BYTES = 8;
    localparam int WIDE_BYTES = 64;
    localparam int META_WID = 32;
    localparam int BEATS_PER_WIDE = WIDE_BYTES / NARROW_BYTES;

    // Derived widths
    localparam int NARROW_DATA_WID = NARROW_BYTES * 8;
    localparam int WIDE_DATA_WID = WIDE_BYTES * 8;
    localparam int NARROW_MTY_WID = $clog2(NARROW_BYTES);
    localparam int WIDE_MTY_WID = $clog2(WIDE_BYTES);
    localparam int SLOT_WID = $clog2(BEATS_PER_WIDE);

    // ====================
    // Beat types
    // ====================

    // Byte 0 sits in the low bits and goes out first
    typedef struct packed {
        logic [NARROW_DATA_WID-1:0] data;
        logic                       eop;
        logic [NARROW_MTY_WID-1:0]  mty;
        logic                       err;
        logic [META_WID-1:0]        meta;
    } narrow_beat_t;

    typedef struct packed {
        logic [WIDE_DATA_WID-1:0] data;
        logic                     eop;
        logic [WIDE_MTY_WID-1:0]  mty;
        logic                     err;
        logic [META_WID-1:0]      meta;
    } wide_beat_t;

    // FIFO read side
    typedef enum logic {
        RD_IDLE,
        RD_SEND
    } fifo_rd_state_t;

endpackage

/* logic/packet_pipe.sv */
`timescale 1ns/1ps

module packet_pipe
    import packet_pkg::*;
#(
    parameter int STAGES = 2
) (
    input  logic         clk,
    input  logic         reset,
    input  narrow_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output narrow_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    // Link 0 is the input, link STAGES the output
    logic [STAGES:0] link_valid;
    logic [STAGES:0] link_ready;
    narrow_beat_t    link_beat [STAGES+1];

    // Held low until the first cycle after reset
    logic running;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign link_valid[0] = in_valid && running;
    assign link_beat[0] = in_beat;
    assign in_ready = link_ready[0] && running;

    assign link_ready[STAGES] = out_ready;
    assign out_valid = link_valid[STAGES];
    assign out_beat = link_beat[STAGES];

    // ====================
    // Register slices
    // ====================
    for (genvar i = 0; i < STAGES; i++) begin : g_slice
        // Slice loads when empty or when its content moves on
        assign link_ready[i] = !link_valid[i+1] || link_ready[i+1];

        always_ff @(posedge clk) begin
            if (reset) begin
                link_valid[i+1] <= 1'b0;
            end else if (link_ready[i]) begin
                link_valid[i+1] <= link_valid[i];
            end
        end

        always_ff @(posedge clk) begin
            if (link_ready[i] && link_valid[i]) begin
                link_beat[i+1] <= link_beat[i];
            end
        end
    end

    // A stalled beat must be held until it is taken
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

/* logic/packet_gather.sv */
`timescale 1ns/1ps

module packet_gather
    import packet_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  narrow_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output wide_beat_t   out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    // Slot of the next narrow beat inside the wide beat
    logic [SLOT_WID-1:0] beat_idx;
    logic                in_xfer;
    logic                closing;
    wide_beat_t          wide_q;

    assign in_ready = !out_valid;
    assign in_xfer = in_valid && in_ready;

    // Wide beat ends on a full set of slots or at end of packet
    assign closing = in_beat.eop || (beat_idx == SLOT_WID'(BEATS_PER_WIDE - 1));

    // ====================
    // Control
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            beat_idx <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (in_xfer) begin
                if (closing) begin
                    beat_idx <= '0;
                    out_valid <= 1'b1;
                end else begin
                    beat_idx <= beat_idx + 1'b1;
                end
            end
        end
    end

    // ====================
    // Payload
    // ====================
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            wide_q.data[beat_idx*NARROW_DATA_WID +: NARROW_DATA_WID] <= in_beat.data;
            if (closing) begin
                wide_q.eop <= in_beat.eop;
                // Unused slots count as empty: (7 - idx) * 8 + narrow mty
                wide_q.mty <= in_beat.eop ? {~beat_idx, in_beat.mty} : '0;
                wide_q.err <= in_beat.err;
                wide_q.meta <= in_beat.meta;
            end
        end
    end

    assign out_beat = wide_q;

endmodule

/* logic/packet_split.sv */
`timescale 1ns/1ps

module packet_split
    import packet_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  wide_beat_t   in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output narrow_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    logic                busy;
    logic [SLOT_WID-1:0] slot;
    logic [SLOT_WID-1:0] last_slot;
    logic                at_last;
    logic                last_eop;
    wide_beat_t          wide_q;

    assign in_ready = !busy;
    assign out_valid = busy;

    // Beat count is 8 - mty/8, so the last slot is its complement
    assign last_slot = ~wide_q.mty[WIDE_MTY_WID-1 -: SLOT_WID];
    assign at_last = (slot == last_slot);
    assign last_eop = wide_q.eop && at_last;

    // ====================
    // Slot walk
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            slot <= '0;
        end else if (!busy) begin
            if (in_valid) begin
                busy <= 1'b1;
                slot <= '0;
            end
        end else if (out_ready) begin
            if (at_last) begin
                busy <= 1'b0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            wide_q <= in_beat;
        end
    end

    // ====================
    // Narrow beat
    // ====================
    always_comb begin
        out_beat.data = wide_q.data[slot*NARROW_DATA_WID +: NARROW_DATA_WID];
        out_beat.eop = last_eop;
        out_beat.mty = last_eop ? wide_q.mty[NARROW_MTY_WID-1:0] : '0;
        out_beat.err = wide_q.err;
        out_beat.meta = wide_q.meta;
    end

    // Only the closing wide beat of a packet may be partly empty
    assert property (@(posedge clk) disable iff (reset)
        in_valid && in_ready && !in_beat.eop |-> in_beat.mty == '0);

endmodule

/* logic/packet_fifo_mem.sv */
`timescale 1ns/1ps

module packet_fifo_mem
    import packet_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  wide_beat_t               wr_beat,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output wide_beat_t               rd_beat
);

    // Wide beat storage
    wide_beat_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // Read is combinational so the head beat is visible with rd_valid
    assign rd_beat = mem[rd_addr];

endmodule

/* logic/packet_fifo_ctrl.sv */
`timescale 1ns/1ps

module packet_fifo_ctrl
    import packet_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_valid,
    output logic                     wr_ready,
    input  logic                     wr_eop,
    output logic                     rd_valid,
    input  logic                     rd_ready,
    input  logic                     rd_eop,
    output logic                     wr_en,
    output logic [$clog2(DEPTH)-1:0] wr_addr,
    output logic [$clog2(DEPTH)-1:0] rd_addr
);

    localparam int ADDR_WID = $clog2(DEPTH);

    logic [ADDR_WID-1:0] wr_ptr;
    logic [ADDR_WID-1:0] rd_ptr;
    logic [ADDR_WID:0]   count;
    logic [ADDR_WID:0]   pkt_count;
    logic                full;
    logic                empty;
    logic                rd_xfer;
    fifo_rd_state_t      rd_state;

    assign full = (count == (ADDR_WID+1)'(DEPTH));
    assign empty = (count == '0);

    assign wr_ready = !full;
    assign wr_en = wr_valid && wr_ready;
    assign wr_addr = wr_ptr;
    assign rd_addr = rd_ptr;

    // Only start on a complete stored packet
    assign rd_valid = (rd_state == RD_SEND) || (pkt_count != '0);
    assign rd_xfer = rd_valid && rd_ready;

    // ====================
    // Pointers and counts
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            pkt_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ADDR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_xfer) begin
                rd_ptr <= (rd_ptr == ADDR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({wr_en, rd_xfer})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase

            case ({wr_en && wr_eop, rd_xfer && rd_eop})
                2'b10: pkt_count <= pkt_count + 1'b1;
                2'b01: pkt_count <= pkt_count - 1'b1;
                default: ;
            endcase
        end
    end

    // ====================
    // Read FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_xfer && !rd_eop) begin
                        rd_state <= RD_SEND;
                    end
                end
                RD_SEND: begin
                    if (rd_xfer && rd_eop) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // Occupancy stays within bounds on both sides
    assert property (@(posedge clk) disable iff (reset) count <= (ADDR_WID+1)'(DEPTH));
    assert property (@(posedge clk) disable iff (reset) rd_xfer |-> !empty);

    // Packet larger than the FIFO can never be released
    assert property (@(posedge clk) disable iff (reset)
        full |-> pkt_count != '0 || rd_state == RD_SEND);

endmodule

/* logic/packet_subsystem.sv */
`timescale 1ns/1ps

module packet_subsystem
    import packet_pkg::*;
#(
    parameter int STAGES = 2,
    parameter int DEPTH = 16
) (
    input  logic         clk,
    input  logic         reset,
    input  narrow_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output narrow_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    // Pipe to gather
    narrow_beat_t pipe_beat;
    logic         pipe_valid;
    logic         pipe_ready;

    // Gather to FIFO
    wide_beat_t wr_beat;
    logic       wr_valid;
    logic       wr_ready;
    logic       wr_en;

    // FIFO to split
    wide_beat_t rd_beat;
    logic       rd_valid;
    logic       rd_ready;

    logic [$clog2(DEPTH)-1:0] wr_addr;
    logic [$clog2(DEPTH)-1:0] rd_addr;

    packet_pipe #(.STAGES(STAGES)) u_pipe (
        .clk, .reset, .in_beat, .in_valid, .in_ready,
        .out_beat(pipe_beat), .out_valid(pipe_valid), .out_ready(pipe_ready)
    );

    packet_gather u_gather (
        .clk, .reset,
        .in_beat(pipe_beat), .in_valid(pipe_valid), .in_ready(pipe_ready),
        .out_beat(wr_beat), .out_valid(wr_valid), .out_ready(wr_ready)
    );

    packet_fifo_ctrl #(.DEPTH(DEPTH)) u_fifo_ctrl (
        .clk, .reset,
        .wr_valid, .wr_ready, .wr_eop(wr_beat.eop),
        .rd_valid, .rd_ready, .rd_eop(rd_beat.eop),
        .wr_en, .wr_addr, .rd_addr
    );

    packet_fifo_mem #(.DEPTH(DEPTH)) u_fifo_mem (
        .clk, .wr_en, .wr_addr, .wr_beat, .rd_addr, .rd_beat
    );

    packet_split u_split (
        .clk, .reset,
        .in_beat(rd_beat), .in_valid(rd_valid), .in_ready(rd_ready),
        .out_beat, .out_valid, .out_ready
    );

endmodule

/* dv/packet_ref_model.sv */
`timescale 1ns/1ps

module packet_ref_model
    import packet_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input narrow_beat_t in_beat,
    input logic         in_valid,
    input logic         in_ready
);

    // Expected bytes in send order and one entry per packet
    logic [7:0]          byte_q [$];
    int                  len_q [$];
    logic [META_WID-1:0] meta_q [$];
    logic                err_q [$];

    int eops_in = 0;
    int eops_out = 0;
    int in_len = 0;
    int out_left = 0;

    // ====================
    // Input capture
    // ====================
    always @(posedge clk) begin
        int n;
        if (!reset && in_valid && in_ready) begin
            n = in_beat.eop ? NARROW_BYTES - int'(in_beat.mty) : NARROW_BYTES;
            for (int i = 0; i < n; i++) begin
                byte_q.push_back(in_beat.data[i*8 +: 8]);
            end
            in_len += n;
            if (in_beat.eop) begin
                len_q.push_back(in_len);
                meta_q.push_back(in_beat.meta);
                err_q.push_back(in_beat.err);
                in_len = 0;
                eops_in++;
            end
        end
    end

    // ====================
    // Output side
    // ====================

    // Head packet has had its eop accepted at the input
    function automatic bit head_complete();
        return eops_in > eops_out;
    endfunction

    function automatic int packets_out();
        return eops_out;
    endfunction

    // Next narrow beat cut from the head packet eight bytes at a time
    function automatic narrow_beat_t next_expected();
        narrow_beat_t want;
        int n;
        want = '0;
        if (out_left == 0) begin
            out_left = len_q.pop_front();
        end
        n = (out_left < NARROW_BYTES) ? out_left : NARROW_BYTES;
        for (int i = 0; i < n; i++) begin
            want.data[i*8 +: 8] = byte_q.pop_front();
        end
        out_left -= n;
        want.meta = meta_q[0];
        want.err = err_q[0];
        if (out_left == 0) begin
            want.eop = 1'b1;
            want.mty = NARROW_MTY_WID'(NARROW_BYTES - n);
            void'(meta_q.pop_front());
            void'(err_q.pop_front());
            eops_out++;
        end
        return want;
    endfunction

endmodule

/* dv/tb_packet_subsystem.sv */
`timescale 1ns/1ps

module tb_packet_subsystem
    import packet_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PACKETS = 100;
    // 100 packets of up to 64 beats, x4 for pauses and back-pressure, plus margin
    localparam int TIMEOUT_CYCLES = 60000;
    localparam logic [31:0] SEED = 32'h27b6_2337;

    logic         clk;
    logic         reset;
    narrow_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;
    narrow_beat_t out_beat;
    logic         out_valid;
    logic         out_ready;

    logic [31:0]  drive_rng = SEED;
    logic [31:0]  sink_rng = SEED ^ 32'h5555_aaaa;
    int           cycles = 0;
    narrow_beat_t held_beat;
    logic         held = 1'b0;

    packet_subsystem #(.STAGES(2), .DEPTH(16)) DUT (
        .clk, .reset, .in_beat, .in_valid, .in_ready,
        .out_beat, .out_valid, .out_ready
    );

    packet_ref_model model (.clk, .reset, .in_beat, .in_valid, .in_ready);

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        drive_rng = xorshift(drive_rng);
        return drive_rng;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_beat(input narrow_beat_t got, input narrow_beat_t want);
        int n;
        n = want.eop ? NARROW_BYTES - int'(want.mty) : NARROW_BYTES;
        if (got.eop !== want.eop) begin
            fail_run($sformatf("Error: time %0t out_beat.eop got %b expected %b",
                $time, got.eop, want.eop));
        end
        if (got.mty !== want.mty) begin
            fail_run($sformatf("Error: time %0t out_beat.mty got %0d expected %0d",
                $time, got.mty, want.mty));
        end
        for (int i = 0; i < n; i++) begin
            if (got.data[i*8 +: 8] !== want.data[i*8 +: 8]) begin
                fail_run($sformatf("Error: time %0t out_beat.data byte %0d got %02h expected %02h",
                    $time, i, got.data[i*8 +: 8], want.data[i*8 +: 8]));
            end
        end
    endtask

    task automatic check_packet_tail(input narrow_beat_t got, input narrow_beat_t want);
        if (got.meta !== want.meta) begin
            fail_run($sformatf("Error: time %0t out_beat.meta got %08h expected %08h",
                $time, got.meta, want.meta));
        end
        if (got.err !== want.err) begin
            fail_run($sformatf("Error: time %0t out_beat.err got %b expected %b",
                $time, got.err, want.err));
        end
    endtask

    // Edge lengths follow the first packet and the rest are random
    function automatic int pick_length(input int idx);
        logic [31:0] r;
        case (idx)
            1: return 64;
            2: return 65;
            3: return 504;
            4: return 511;
            default: begin
                r = next_random();
                return 64 + int'(r % 448);
            end
        endcase
    endfunction

    task automatic send_packet(input int len);
        narrow_beat_t beat;
        logic [31:0]  r;
        int           sent;
        int           n;
        bit           taken;
        beat.meta = next_random();
        r = next_random();
        beat.err = r[0];
        sent = 0;
        while (sent < len) begin
            n = (len - sent < NARROW_BYTES) ? len - sent : NARROW_BYTES;
            beat.data = {next_random(), next_random()};
            beat.eop = (sent + n == len);
            beat.mty = NARROW_MTY_WID'(NARROW_BYTES - n);
            r = next_random();
            if (r[0]) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            in_beat = beat;
            in_valid = 1'b1;
            do begin
                @(negedge clk);
                taken = in_ready;
                @(posedge clk);
                #1;
            end while (!taken);
            sent += n;
        end
        in_valid = 1'b0;
    endtask

    // ====================
    // Clock, sink, timeout
    // ====================
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            sink_rng = xorshift(sink_rng);
            out_ready = sink_rng[0];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: not all packets came out within the cycle limit");
        end
    end

    // ====================
    // Output monitor
    // ====================
    always @(negedge clk) begin
        narrow_beat_t want;
        if (!reset) begin
            // Stalled beat must stay put
            if (held) begin
                if (out_valid !== 1'b1) begin
                    fail_run("out_valid dropped before the stalled beat was taken");
                end
                check_beat(out_beat, held_beat);
                check_packet_tail(out_beat, held_beat);
            end
            if (out_valid === 1'b1 && !model.head_complete()) begin
                fail_run("out_valid rose before the last input beat of the packet was accepted");
            end
            if (out_valid === 1'b1 && out_ready === 1'b1) begin
                want = model.next_expected();
                check_beat(out_beat, want);
                if (want.eop) begin
                    check_packet_tail(out_beat, want);
                end
            end
            held = out_valid && !out_ready;
            held_beat = out_beat;
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        reset = 1'b1;
        in_beat = '0;
        in_valid = 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b0) begin
            fail_run("out_valid or in_ready was high during reset");
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        while (in_ready !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        for (int p = 0; p < NUM_PACKETS; p++) begin
            send_packet(pick_length(p));
        end
        while (model.packets_out() < NUM_PACKETS) begin
            @(negedge clk);
        end
        // Split goes idle once the last beat is taken
        @(negedge clk);
        if (out_valid === 1'b0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_run("out_valid stayed high after the last packet came out");
        end
    end

endmodule

/* files.f */
logic/packet_pkg.sv
logic/packet_pipe.sv
logic/packet_gather.sv
logic/packet_split.sv
logic/packet_fifo_mem.sv
logic/packet_fifo_ctrl.sv
logic/packet_subsystem.sv
dv/packet_ref_model.sv
dv/tb_packet_subsystem.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_packet_subsystem \
    -f files.f \
    -o sim_packet_subsystem

./obj_dir/sim_packet_subsystem
